// ==== Makefile ====
TOP = tb_stack_soc
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
  input  logic               clk,
  input  logic               rst,
  input  mem_map_pkg::addr_t addr,
  input  logic               wr,
  input  isa_pkg::word_t     wr_data,
  output isa_pkg::word_t     rd_data,
  output logic [7:0]         uart_data,
  output logic               uart_valid
);

  import isa_pkg::*;
  import mem_map_pkg::*;

  // 20h-ffh maps onto entries 0-223
  word_t       ram [224];
  mem_region_e region;
  logic [7:0]  ram_idx;

  assign region  = region_of(addr);
  assign ram_idx = addr - 8'h20;

  // registered read, non-ram regions read zero (uart rx absent)
  always_ff @(posedge clk) begin
    if (region == region_ram) begin
      rd_data <= ram[ram_idx];
    end else begin
      rd_data <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr && (region == region_ram)) begin
      ram[ram_idx] <= wr_data;
    end
  end

  // low byte goes out, valid for the cycle after the write edge
  always_ff @(posedge clk) begin
    if (wr && (region == region_uart)) begin
      uart_data <= wr_data[7:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      uart_valid <= 1'b0;
    end else begin
      uart_valid <= wr && (region == region_uart);
    end
  end

endmodule

// ==== hdl/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder (
  input  isa_pkg::insn_t      insn,
  output logic                imm,
  output isa_pkg::load_sel_e  load,
  output logic                rd,
  output logic                wr,
  output logic                pop,
  output logic                push,
  output isa_pkg::jump_cond_e jmp,
  output logic                halt
);

  import isa_pkg::*;

  opcode_e opcode;

  assign opcode = opcode_e'(insn[15:8]);

  // only the full ffffh word halts, other ffxx words do nothing
  assign halt = (opcode == op_halt) && (insn[7:0] == 8'hFF);

  always_comb begin
    // unknown opcodes fall through as a no-op
    imm  = 1'b0;
    load = ld_keep;
    rd   = 1'b0;
    wr   = 1'b0;
    pop  = 1'b0;
    push = 1'b0;
    jmp  = jmp_none;
    case (opcode)
      op_push: begin
        imm  = 1'b1;
        load = ld_alu;
        push = 1'b1;
      end
      op_pop: begin
        load = ld_second;
        pop  = 1'b1;
      end
      op_dup: begin
        // bit 0 picks which entry gets copied to the top
        load = insn[0] ? ld_second : ld_keep;
        push = 1'b1;
      end
      op_ld: begin
        imm  = 1'b1;
        load = ld_rd;
        rd   = 1'b1;
        push = 1'b1;
      end
      op_st: begin
        imm  = 1'b1;
        load = ld_second;
        wr   = 1'b1;
        pop  = 1'b1;
      end
      // address on top, data below; the address stays
      op_sta: begin
        wr  = 1'b1;
        pop = 1'b1;
      end
      // same store, but the data is left on top
      op_std: begin
        load = ld_second;
        wr   = 1'b1;
        pop  = 1'b1;
      end
      op_jmp: begin
        imm = 1'b1;
        jmp = jmp_always;
      end
      op_jz: begin
        imm  = 1'b1;
        load = ld_second;
        pop  = 1'b1;
        jmp  = jmp_zero;
      end
      op_alu: begin
        load = ld_alu;
        pop  = 1'b1;
      end
      default: begin
        imm = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  `include "stack_cpu_config.svh"

  // raw instruction, opcode in [15:8] and imm8 in [7:0]
  typedef logic [15:0] insn_t;
  // stack entry and data bus word
  typedef logic [15:0] word_t;
  typedef logic [`PC_WIDTH-1:0] pc_t;

  // opcode groups: 00-07 stack, 08-0f memory, 10-1f jump, 20 alu
  typedef enum logic [7:0] {
    op_push = 8'h00,
    op_pop  = 8'h01,
    op_dup  = 8'h02,
    op_ld   = 8'h08,
    op_st   = 8'h0C,
    op_sta  = 8'h0D,
    op_std  = 8'h0E,
    op_jmp  = 8'h10,
    op_jz   = 8'h11,
    op_alu  = 8'h20,
    op_halt = 8'hFF
  } opcode_e;

  // alu function, carried in imm8 of an alu instruction
  typedef enum logic [7:0] {
    alu_pass0 = 8'h00,
    alu_pass1 = 8'h01,
    alu_add   = 8'h02,
    alu_sub   = 8'h03,
    alu_mul   = 8'h04,
    alu_join  = 8'h05,
    alu_and   = 8'h06,
    alu_lt    = 8'h08,
    alu_eq    = 8'h09,
    alu_neq   = 8'h0A
  } alu_func_e;

  // new top of stack source
  typedef enum logic [1:0] {ld_keep, ld_second, ld_alu, ld_rd} load_sel_e;

  typedef enum logic [1:0] {jmp_none, jmp_always, jmp_zero} jump_cond_e;

  typedef enum logic [1:0] {ph_execute, ph_memory, ph_update, ph_wait} phase_e;

endpackage

// ==== hdl/mem_map_pkg.sv ====
package mem_map_pkg;

  // data bus address, 256 words
  typedef logic [7:0] addr_t;

  typedef enum logic [1:0] {
    region_unused,
    region_uart,
    region_reserved,
    region_ram
  } mem_region_e;

  // 00h unused, 01h uart, 02h-1fh reserved, 20h-ffh ram
  function automatic mem_region_e region_of(input addr_t addr);
    if (addr == 8'h00) return region_unused;
    else if (addr == 8'h01) return region_uart;
    else if (addr < 8'h20) return region_reserved;
    else return region_ram;
  endfunction

endpackage

// ==== hdl/operand_stack.sv ====
`timescale 1ns/1ps

`include "stack_cpu_config.svh"

module operand_stack (
  input  logic               clk,
  input  logic               rst,
  input  logic               update,
  input  isa_pkg::load_sel_e load,
  input  logic               push,
  input  logic               pop,
  input  isa_pkg::word_t     alu_result,
  input  isa_pkg::word_t     rd_data,
  output isa_pkg::word_t     tos,
  output isa_pkg::word_t     nos
);

  import isa_pkg::*;

  // entry 0 is the top
  word_t stack_q [`STACK_DEPTH];

  assign tos = stack_q[0];
  assign nos = stack_q[1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `STACK_DEPTH; i++) begin
        stack_q[i] <= '0;
      end
    end else if (update) begin
      case (load)
        ld_keep:   stack_q[0] <= stack_q[0];
        ld_second: stack_q[0] <= stack_q[1];
        ld_alu:    stack_q[0] <= alu_result;
        ld_rd:     stack_q[0] <= rd_data;
        default:   stack_q[0] <= stack_q[0];
      endcase
      // push shifts down, bottom entry drops off
      if (push && !pop) begin
        for (int i = 1; i < `STACK_DEPTH; i++) begin
          stack_q[i] <= stack_q[i-1];
        end
      end
      // pop shifts up, bottom entry keeps its value
      if (pop && !push) begin
        for (int i = 1; i < `STACK_DEPTH - 1; i++) begin
          stack_q[i] <= stack_q[i+1];
        end
      end
    end
  end

endmodule

// ==== hdl/stack_alu.sv ====
`timescale 1ns/1ps

module stack_alu (
  input  logic           imm,
  input  logic [7:0]     imm8,
  input  isa_pkg::word_t tos,
  input  isa_pkg::word_t nos,
  output isa_pkg::word_t result
);

  import isa_pkg::*;

  alu_func_e func;

  // imm8 doubles as the function select when not an immediate
  assign func = alu_func_e'(imm8);

  always_comb begin
    if (imm) begin
      result = {8'h00, imm8};
    end else begin
      case (func)
        alu_pass0: result = tos;
        alu_pass1: result = nos;
        alu_add:   result = tos + nos;
        alu_sub:   result = tos - nos;
        // low 16 bits of the product
        alu_mul:   result = tos * nos;
        // nos becomes the high byte
        alu_join:  result = tos | (nos << 8);
        alu_and:   result = tos & nos;
        // compares give 0 or 1
        alu_lt:    result = word_t'(tos < nos);
        alu_eq:    result = word_t'(tos == nos);
        alu_neq:   result = word_t'(tos != nos);
        default:   result = '0;
      endcase
    end
  end

endmodule

// ==== hdl/stack_cpu.sv ====
`timescale 1ns/1ps

`include "stack_cpu_config.svh"

module stack_cpu (
  input  logic                clk,
  input  logic                rst,
  input  isa_pkg::insn_t      insn,
  output isa_pkg::pc_t        pc,
  output mem_map_pkg::addr_t  mem_addr,
  output logic                mem_wr,
  output isa_pkg::word_t      wr_data,
  input  isa_pkg::word_t      rd_data
);

  import isa_pkg::*;

  logic       imm;
  logic       rd;
  logic       wr;
  logic       pop;
  logic       push;
  logic       halt;
  load_sel_e  load;
  jump_cond_e jmp;
  logic [7:0] imm8;
  word_t      tos;
  word_t      nos;
  word_t      alu_out;
  word_t      load_data;
  phase_e     phase;
  logic [15:0] wait_cnt;
  logic       jump_taken;

  assign imm8 = insn[7:0];
  // address comes straight from the alu, so imm8 for ld/st, tos for sta/std
  assign mem_addr = alu_out[7:0];
  // read data only reaches the stack on loads
  assign load_data = rd ? rd_data : '0;
  // jz tests the top before it is popped
  assign jump_taken = (jmp == jmp_always) || ((jmp == jmp_zero) && (tos == '0));

  insn_decoder u_decoder (
    .insn (insn),
    .imm  (imm),
    .load (load),
    .rd   (rd),
    .wr   (wr),
    .pop  (pop),
    .push (push),
    .jmp  (jmp),
    .halt (halt)
  );

  stack_alu u_alu (
    .imm    (imm),
    .imm8   (imm8),
    .tos    (tos),
    .nos    (nos),
    .result (alu_out)
  );

  operand_stack u_stack (
    .clk        (clk),
    .rst        (rst),
    .update     (phase == ph_update),
    .load       (load),
    .push       (push),
    .pop        (pop),
    .alu_result (alu_out),
    .rd_data    (load_data),
    .tos        (tos),
    .nos        (nos)
  );

  // execute, memory, update, then CLK_DIVIDER wait cycles
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase    <= ph_execute;
      wait_cnt <= '0;
    end else if (phase != ph_wait) begin
      phase    <= phase_e'(phase + 2'd1);
      wait_cnt <= '0;
    end else if (wait_cnt == 16'(`CLK_DIVIDER - 1)) begin
      phase    <= ph_execute;
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 16'd1;
    end
  end

  // strobe covers exactly the update phase
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_wr <= 1'b0;
    end else begin
      mem_wr <= (phase == ph_memory) && wr;
    end
  end

  // st writes the top, sta/std write the entry under the address
  always_ff @(posedge clk) begin
    if (phase == ph_memory) begin
      wr_data <= imm ? tos : nos;
    end
  end

  // relative jump, imm8 sign extended to pc width
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if ((phase == ph_update) && !halt) begin
      if (jump_taken) begin
        pc <= pc + pc_t'($signed(imm8));
      end else begin
        pc <= pc + pc_t'(1);
      end
    end
  end

endmodule

// ==== hdl/stack_cpu_config.svh ====
`ifndef STACK_CPU_CONFIG_SVH
`define STACK_CPU_CONFIG_SVH

// operand stack entries
// bottom entry is lost on push and kept on pop
`define STACK_DEPTH 8

// program counter width, 1k instruction words
`define PC_WIDTH 10

// wait phase length in clocks, must be 1 or more
// one instruction takes 3 + CLK_DIVIDER clocks
`define CLK_DIVIDER 1

`endif

// ==== hdl/stack_soc.sv ====
`timescale 1ns/1ps

module stack_soc (
  input  logic           clk,
  input  logic           rst,
  input  isa_pkg::insn_t insn,
  output isa_pkg::pc_t   pc,
  output logic [7:0]     uart_data,
  output logic           uart_valid
);

  // processor to data memory bus
  mem_map_pkg::addr_t mem_addr;
  logic               mem_wr;
  isa_pkg::word_t     wr_data;
  isa_pkg::word_t     rd_data;

  stack_cpu u_cpu (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .pc       (pc),
    .mem_addr (mem_addr),
    .mem_wr   (mem_wr),
    .wr_data  (wr_data),
    .rd_data  (rd_data)
  );

  data_memory u_dmem (
    .clk        (clk),
    .rst        (rst),
    .addr       (mem_addr),
    .wr         (mem_wr),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .uart_data  (uart_data),
    .uart_valid (uart_valid)
  );

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/mem_map_pkg.sv
hdl/insn_decoder.sv
hdl/stack_alu.sv
hdl/operand_stack.sv
hdl/stack_cpu.sv
hdl/data_memory.sv
hdl/stack_soc.sv
testbench/tb_stack_soc.sv

// ==== testbench/program_input.txt ====
# P: program words in hex from address 000 upward, E: expected uart bytes in order
# H: address where pc stops on the halt word
# push, dup, over, pop and st to the uart
P 0001 0002 0003 0C01 0200 0C01 0100 0C01
P 0005 0006 0201 0C01 0C01 0100
# alu functions on pushed pairs, join and mul truncation via lt and eq
P 0011 0022 2000 0C01 0011 0022 2001 0C01
P 0030 000C 2002 0C01 0005 0003 2003 0C01
P 0013 000B 2004 0C01 0012 0034 2005 0200
P 0C01 00FF 2008 0C01 003C 000F 2006 0C01
P 0005 0003 2008 0C01 0003 0005 2008 0C01
P 0007 0007 2009 0C01 0007 0007 200A 0C01
P 0007 0008 200A 0C01 0001 0000 2005 0200
P 2004 0000 2009 0C01 0005 0006 2007 0C01
# ram round trip at 20 and ff, reads of 01 and a reserved address
P 005A 0C20 00A5 0CFF 0820 0C01 08FF 0C01
P 0801 0C01 0077 0C10 0810 0C01
# sta keeps the address, std keeps the data
P 009C 0021 0D00 0C01 0821 0C01 003E 0022
P 0E00 0C01 0822 0C01
# counter at 23 counts down from 3, forward jmp skips dead code
P 0003 0C23 1003 00EE 0C01 0823 1108 0823
P 0C01 0001 0823 2003 0C23 10F8 FFFF
E 03 02 01 05 06
E 22 11 3C FE D1 34 01 0C 01 00 01 00 01 01 00
E 5A A5 00 00 21 9C 3E 3E
E 03 02 01
H 076

// ==== testbench/tb_stack_soc.sv ====
`timescale 1ns/1ps

module tb_stack_soc;

  import isa_pkg::*;

  localparam int uart_timeout = 400;
  localparam int halt_timeout = 4000;
  // cycles of unchanged pc that count as halted
  localparam int halt_hold    = 8;

  logic       clk;
  logic       rst;
  insn_t      insn;
  pc_t        pc;
  logic [7:0] uart_data;
  logic       uart_valid;

  // contents of the input file
  insn_t      prog [$];
  logic [7:0] exp_bytes [$];
  pc_t        exp_halt;

  int pulse_count = 0;

  stack_soc uut (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .pc         (pc),
    .uart_data  (uart_data),
    .uart_valid (uart_valid)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // fetch reads the halt word past the end of the program
  always @(posedge clk) begin
    if (int'(pc) < prog.size()) begin
      insn <= prog[pc];
    end else begin
      insn <= 16'hFFFF;
    end
  end

  // counts every uart strobe for the final check
  always @(negedge clk) begin
    if (uart_valid) begin
      pulse_count++;
    end
  end

  task automatic end_in_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped on the first failure");
  endtask

  task automatic check_uart(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %02h actual %02h", name, expected, actual);
      end_in_failure();
    end
  endtask

  task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %03h actual %03h", name, expected, actual);
      end_in_failure();
    end
  endtask

  // tag tokens P, E, H switch the list that the hex words go to
  task automatic load_input();
    int                fd;
    int                code;
    logic [8*16-1:0]   tok;
    logic [8*128-1:0]  rest;
    logic [15:0]       val;
    logic [7:0]        mode;
    mode = 8'h00;
    fd = $fopen("testbench/program_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/program_input.txt");
      end_in_failure();
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == 128'("#")) begin
          // rest of the line is a comment
          code = $fgets(rest, fd);
        end else if (tok == 128'("P") || tok == 128'("E") || tok == 128'("H")) begin
          mode = tok[7:0];
        end else begin
          code = $sscanf(tok, "%h", val);
          // a malformed word would leave val stale
          if (code != 1) begin
            $display("input file token %0s is not a hex word", tok);
            end_in_failure();
          end else if (mode == "P") begin
            prog.push_back(val);
          end else if (mode == "E") begin
            exp_bytes.push_back(val[7:0]);
          end else if (mode == "H") begin
            exp_halt = pc_t'(val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // valid is high for one full cycle so each falling edge sees it once
  task automatic wait_uart_byte(input int idx, output logic [7:0] data);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!uart_valid) begin
      if (cycles >= uart_timeout) begin
        $display("timeout: uart byte %0d did not arrive within %0d cycles", idx, uart_timeout);
        end_in_failure();
      end
      @(negedge clk);
      cycles++;
    end
    data = uart_data;
  endtask

  // halted once pc stays put for longer than one instruction
  task automatic wait_for_halt();
    int  cycles;
    int  stable;
    pc_t last_pc;
    cycles  = 0;
    stable  = 0;
    last_pc = pc;
    while (stable < halt_hold) begin
      @(negedge clk);
      cycles++;
      if (pc == last_pc) begin
        stable++;
      end else begin
        stable  = 0;
        last_pc = pc;
      end
      if (cycles >= halt_timeout) begin
        $display("timeout: pc never stopped within %0d cycles", halt_timeout);
        end_in_failure();
      end
    end
  endtask

  initial begin
    logic [7:0] got;
    clk  = 1'b0;
    rst  = 1'b1;
    insn = '0;
    load_input();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // bytes come out in program order
    foreach (exp_bytes[i]) begin
      wait_uart_byte(i, got);
      check_uart($sformatf("uart byte %0d", i), exp_bytes[i], got);
    end
    wait_for_halt();
    check_pc("halt address", exp_halt, pc);
    if (pulse_count != exp_bytes.size()) begin
      $display("uart sent %0d bytes but %0d were expected", pulse_count, exp_bytes.size());
      end_in_failure();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule
